//--- sources.f
verilog/add_pkg.sv
verilog/add_byte_gp.sv
verilog/add_glb_carry.sv
verilog/add_sum_sel.sv
verilog/add_unit.sv
bench/tb_clk_gen.sv
bench/add_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the adder unit testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir
EXE=add_tb_sim

verilator --binary --timing --assert \
   -f sources.f \
   --top-module add_tb \
   --Mdir "$MDIR" \
   -o "$EXE"
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$MDIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
   exit 0
fi

echo "pass line not found in $LOG"
exit 1

//--- bench/add_tb.sv
//--------------------
// Adder unit testbench
// Directed tests against a 65-bit reference sum, with an
// in-order response queue, latency check and watchdog.
//--------------------

`timescale 1ns/1ps

module add_tb;

   localparam int N_OPS = 16 + 7 + 11 + 200;

   // one outstanding request, its expected response and strobe cycle
   typedef struct packed {
      add_pkg::add_rsp_t rsp;
      logic [31:0]       cyc;
   } pend_t;

   logic              clk;
   logic              rst;
   logic              in_valid;
   add_pkg::add_req_t req;
   logic              out_valid;
   add_pkg::add_rsp_t rsp;
   logic [31:0]       cyc = '0;
   int                errors = 0;
   pend_t             exp_q[$];
   pend_t             e;

   tb_clk_gen i_clk_gen (
      .clk (clk),
      .rst (rst)
   );

   add_unit i_dut (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .req       (req),
      .out_valid (out_valid),
      .rsp       (rsp)
   );

   always @(posedge clk) cyc <= cyc + 32'd1;

   function automatic add_pkg::add_rsp_t model_rsp(input add_pkg::add_req_t r);
      logic [63:0]       xv;
      logic [63:0]       yv;
      logic              cv;
      logic [64:0]       full;
      add_pkg::add_rsp_t m;
      xv = r.a;
      yv = r.b;
      cv = 1'b0;
      if (r.op == add_pkg::op_sub) begin
         yv = ~r.b;
         cv = 1'b1;
      end else if (r.op == add_pkg::op_adc) begin
         cv = r.cin;
      end
      full   = {1'b0, xv} + {1'b0, yv} + 65'(cv);
      m.sum  = full[63:0];
      m.cout = full[64];
      m.ovf  = (xv[63] == yv[63]) && (full[63] != xv[63]);
      m.zero = (full[63:0] == 64'h0);
      return m;
   endfunction

   task automatic compare_field(input string name, input logic [63:0] exp,
                                input logic [63:0] got);
      if (got !== exp) begin
         $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   // responses are checked in order on the falling edge
   always @(negedge clk) begin
      if (out_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("out_valid at %0t with no request outstanding", $time);
            errors++;
         end else begin
            e = exp_q.pop_front();
            if (e.cyc + 32'd2 != cyc) begin
               $display("response for strobe at cycle %0d came at cycle %0d, not 2 later",
                        e.cyc, cyc);
               errors++;
            end
            compare_field("rsp.sum", e.rsp.sum, rsp.sum);
            compare_field("rsp.cout", 64'(e.rsp.cout), 64'(rsp.cout));
            compare_field("rsp.ovf", 64'(e.rsp.ovf), 64'(rsp.ovf));
            compare_field("rsp.zero", 64'(e.rsp.zero), 64'(rsp.zero));
         end
      end
   end

   task automatic issue_op(input add_pkg::add_op_e op, input logic [63:0] a,
                           input logic [63:0] b, input logic cin);
      add_pkg::add_req_t r;
      pend_t             p;
      r.a   = a;
      r.b   = b;
      r.op  = op;
      r.cin = cin;
      @(negedge clk);
      in_valid = 1'b1;
      req      = r;
      p.rsp    = model_rsp(r);
      p.cyc    = cyc;
      exp_q.push_back(p);
   endtask

   // end the burst and wait for the outstanding responses
   task automatic drain();
      int n;
      n = 0;
      @(negedge clk);
      in_valid = 1'b0;
      while (exp_q.size() != 0 && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d responses never arrived, out_valid missing", exp_q.size());
         errors += exp_q.size();
         exp_q.delete();
      end
   endtask

   task automatic reset_idle();
      repeat (3) begin
         @(negedge clk);
         if (out_valid !== 1'b0) begin
            $display("ERR %0t out_valid exp 0 got %b", $time, out_valid);
            errors++;
         end
      end
      wait (rst == 1'b0);
      repeat (8) begin
         @(negedge clk);
         if (out_valid !== 1'b0) begin
            $display("ERR %0t out_valid exp 0 got %b", $time, out_valid);
            errors++;
         end
      end
   endtask

   // all ones plus a single bit at each byte boundary, both operand orders
   task automatic carry_chains();
      for (int k = 0; k < 8; k++) begin
         issue_op(add_pkg::op_add, ~64'h0, 64'h1 << (8 * k), 1'b0);
         issue_op(add_pkg::op_add, 64'h1 << (8 * k), ~64'h0, 1'b0);
      end
      drain();
   endtask

   task automatic sub_overflow();
      logic [63:0] a;
      a = {$urandom, $urandom};
      issue_op(add_pkg::op_sub, a, a, 1'b0);
      issue_op(add_pkg::op_sub, 64'h0, 64'h0, 1'b0);
      issue_op(add_pkg::op_sub, 64'h8000_0000_0000_0000, 64'h1, 1'b0);
      issue_op(add_pkg::op_add, 64'h7fff_ffff_ffff_ffff, 64'h1, 1'b0);
      issue_op(add_pkg::op_sub, 64'd5, 64'd7, 1'b0);
      issue_op(add_pkg::op_sub, 64'd100, 64'd1000, 1'b0);
      issue_op(add_pkg::op_sub, 64'h0, 64'h1, 1'b0);
      drain();
   endtask

   task automatic add_with_carry();
      for (int i = 0; i < 4; i++) begin
         issue_op(add_pkg::op_adc, {$urandom, $urandom}, {$urandom, $urandom}, 1'b0);
         issue_op(add_pkg::op_adc, {$urandom, $urandom}, {$urandom, $urandom}, 1'b1);
      end
      issue_op(add_pkg::op_adc, ~64'h0, ~64'h0, 1'b0);
      issue_op(add_pkg::op_adc, ~64'h0, ~64'h0, 1'b1);
      // cin alone carries through all eight bytes
      issue_op(add_pkg::op_adc, ~64'h0, 64'h0, 1'b1);
      drain();
   endtask

   task automatic back_to_back();
      logic [63:0]      a;
      logic [63:0]      b;
      add_pkg::add_op_e op;
      for (int i = 0; i < 200; i++) begin
         op = add_pkg::add_op_e'(2'($urandom_range(0, 2)));
         a  = {$urandom, $urandom};
         case ($urandom_range(0, 3))
            0: b = {$urandom, $urandom};
            // long transmit runs, matched to a for sub
            1: b = (op == add_pkg::op_sub) ? a : ~a;
            2: b = ((op == add_pkg::op_sub) ? a : ~a) ^ (64'h1 << $urandom_range(0, 63));
            default: begin
               a = ~64'h0 >> $urandom_range(0, 63);
               b = 64'h1;
            end
         endcase
         issue_op(op, a, b, 1'($urandom));
      end
      drain();
   endtask

   initial begin
      #(4 * (N_OPS + 200));
      $display("timeout, the tests did not finish within the watchdog limit");
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      in_valid = 1'b0;
      req      = '0;
      void'($urandom(32'h082d_d35b));
      reset_idle();
      carry_chains();
      sub_overflow();
      add_with_carry();
      back_to_back();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- bench/tb_clk_gen.sv
//--------------------
// Testbench clock and reset
// 4 ns clock, reset high for the first 3 cycles
//--------------------

`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // release on a falling edge, away from the DUT sampling edge
   initial begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

//--- verilog/add_unit.sv
//--------------------
// 64-bit adder unit
// Stages one operation per strobe, conditions the operands by
// opcode, adds them in a carry-select datapath and registers
// the flagged result two edges after the strobe.
//--------------------

`timescale 1ns/1ps

module add_unit (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid,
   input  add_pkg::add_req_t req,
   output logic              out_valid,
   output add_pkg::add_rsp_t rsp
);

   logic               stg_vld;
   add_pkg::add_req_t  stg_req;
   add_pkg::add_word_t x;
   add_pkg::add_word_t y;
   logic               ci;
   add_pkg::byte_sig_t g08;
   add_pkg::byte_sig_t t08;
   add_pkg::byte_sig_t c64_b;
   add_pkg::add_word_t sum0;
   add_pkg::add_word_t sum1;
   add_pkg::add_rsp_t  nxt_rsp;

   // valid pipeline
   always_ff @(posedge clk) begin
      if (rst) begin
         stg_vld   <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         stg_vld   <= in_valid;
         out_valid <= stg_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         stg_req <= req;
      end
      if (stg_vld) begin
         rsp <= nxt_rsp;
      end
   end

   // operand conditioning
   assign x = stg_req.a;

   always_comb begin
      y  = stg_req.b;
      ci = 1'b0;
      case (stg_req.op)
         add_pkg::op_sub: begin
            y  = ~stg_req.b;
            ci = 1'b1;
         end
         add_pkg::op_adc: begin
            ci = stg_req.cin;
         end
         default: begin
            ci = 1'b0;
         end
      endcase
   end

   add_byte_gp i_byte_gp (
      .x    (x),
      .y    (y),
      .g08  (g08),
      .t08  (t08),
      .sum0 (sum0),
      .sum1 (sum1)
   );

   add_glb_carry i_glb_carry (
      .g08   (g08),
      .t08   (t08),
      .ci    (ci),
      .c64_b (c64_b)
   );

   add_sum_sel i_sum_sel (
      .c64_b (c64_b),
      .ci    (ci),
      .sum0  (sum0),
      .sum1  (sum1),
      .x_msb (x[0]),
      .y_msb (y[0]),
      .rsp   (nxt_rsp)
   );

   // every strobe gives exactly one result two edges later
   a_latency : assert property (
      @(posedge clk) disable iff (rst)
      (!$past(rst) && !$past(rst, 2)) |-> (out_valid == $past(in_valid, 2))
   );

   // staged opcode stays within the defined encodings
   a_op_legal : assert property (
      @(posedge clk) disable iff (rst)
      stg_vld |-> (stg_req.op inside {add_pkg::op_add, add_pkg::op_sub, add_pkg::op_adc})
   );

endmodule

//--- verilog/add_sum_sel.sv
//--------------------
// Adder sum select
// Picks each byte's sum by its incoming carry and forms
// the carry out, signed overflow and zero flags.
//--------------------

`timescale 1ns/1ps

module add_sum_sel (
   input  add_pkg::byte_sig_t c64_b,
   input  logic               ci,
   input  add_pkg::add_word_t sum0,
   input  add_pkg::add_word_t sum1,
   input  logic               x_msb,
   input  logic               y_msb,
   output add_pkg::add_rsp_t  rsp
);

   add_pkg::byte_sig_t byte_ci;
   add_pkg::add_word_t sum;

   // carry into byte k is the carry out of byte k+1, ci feeds byte 7
   assign byte_ci = {~c64_b[1:7], ci};

   always_comb begin
      for (int k = 0; k < 8; k++) begin
         if (byte_ci[k]) begin
            sum[8*k +: 8] = sum1[8*k +: 8];
         end else begin
            sum[8*k +: 8] = sum0[8*k +: 8];
         end
      end
   end

   assign rsp.sum  = sum;
   assign rsp.cout = ~c64_b[0];
   // operands agree in sign but the result does not
   assign rsp.ovf  = (x_msb == y_msb) && (sum[0] != x_msb);
   assign rsp.zero = ~|sum;

endmodule

//--- verilog/add_glb_carry.sv
//--------------------
// Adder global carry lookahead
// Turns byte group generate/transmit and the global carry-in
// into the inverted carry out of each byte. Terms alternate
// between true and inverted phase through the tree.
//--------------------

`timescale 1ns/1ps

module add_glb_carry (
   input  add_pkg::byte_sig_t g08,
   input  add_pkg::byte_sig_t t08,
   input  logic               ci,
   output add_pkg::byte_sig_t c64_b
);

   // byte 7 merged with ci, used by every byte
   logic       g7c_b;
   // bytes 1..7, shared by bytes 0 and 1
   logic [0:3] b1_g16_b;
   logic [0:2] b1_t16_b;
   logic [0:1] b1_g32;
   logic       b1_t32;
   logic       g56_b;
   logic       b0_c64;
   // shorter trees for bytes 2..6
   logic [0:3] b2_g16_b;
   logic [0:2] b2_t16_b;
   logic [0:1] b2_g32;
   logic       b2_t32;
   logic [0:3] b3_g16_b;
   logic [0:2] b3_t16_b;
   logic [0:1] b3_g32;
   logic       b3_t32;
   logic [0:1] b4_g32;
   logic       b4_t32;
   logic [0:1] b5_g32;
   logic       b5_t32;
   logic       b6_g32;

   assign g7c_b = ~(g08[7] | (t08[7] & ci));

   // bytes 1..7 with ci
   assign b1_g16_b[0] = ~(g08[1] | (t08[1] & g08[2]));
   assign b1_g16_b[1] = ~(g08[3] | (t08[3] & g08[4]));
   assign b1_g16_b[2] = ~(g08[5] | (t08[5] & g08[6]));
   assign b1_g16_b[3] = g7c_b;
   assign b1_t16_b[0] = ~(t08[1] & t08[2]);
   assign b1_t16_b[1] = ~(t08[3] & t08[4]);
   assign b1_t16_b[2] = ~(t08[5] & t08[6]);
   assign b1_g32[0]   = ~(b1_g16_b[0] & (b1_t16_b[0] | b1_g16_b[1]));
   assign b1_g32[1]   = ~(b1_g16_b[2] & (b1_t16_b[2] | b1_g16_b[3]));
   assign b1_t32      = ~(b1_t16_b[0] | b1_t16_b[1]);
   assign g56_b       = ~(b1_g32[0] | (b1_t32 & b1_g32[1]));

   // full word carry out adds byte 0's own group
   assign b0_c64   = ~(~g08[0] & (~t08[0] | g56_b));
   assign c64_b[0] = ~b0_c64;
   assign c64_b[1] = g56_b;

   // bytes 2..7
   assign b2_g16_b[0] = ~(g08[2] | (t08[2] & g08[3]));
   assign b2_g16_b[1] = ~(g08[4] | (t08[4] & g08[5]));
   assign b2_g16_b[2] = ~g08[6];
   assign b2_g16_b[3] = g7c_b;
   assign b2_t16_b[0] = ~(t08[2] & t08[3]);
   assign b2_t16_b[1] = ~(t08[4] & t08[5]);
   assign b2_t16_b[2] = ~t08[6];
   assign b2_g32[0]   = ~(b2_g16_b[0] & (b2_t16_b[0] | b2_g16_b[1]));
   assign b2_g32[1]   = ~(b2_g16_b[2] & (b2_t16_b[2] | b2_g16_b[3]));
   assign b2_t32      = ~(b2_t16_b[0] | b2_t16_b[1]);
   assign c64_b[2]    = ~(b2_g32[0] | (b2_t32 & b2_g32[1]));

   // bytes 3..7
   assign b3_g16_b[0] = ~(g08[3] | (t08[3] & g08[4]));
   assign b3_g16_b[1] = ~g08[5];
   assign b3_g16_b[2] = ~g08[6];
   assign b3_g16_b[3] = g7c_b;
   assign b3_t16_b[0] = ~(t08[3] & t08[4]);
   assign b3_t16_b[1] = ~t08[5];
   assign b3_t16_b[2] = ~t08[6];
   assign b3_g32[0]   = ~(b3_g16_b[0] & (b3_t16_b[0] | b3_g16_b[1]));
   assign b3_g32[1]   = ~(b3_g16_b[2] & (b3_t16_b[2] | b3_g16_b[3]));
   assign b3_t32      = ~(b3_t16_b[0] | b3_t16_b[1]);
   assign c64_b[3]    = ~(b3_g32[0] | (b3_t32 & b3_g32[1]));

   // bytes 4..7, the 16-bit level collapses to single bytes
   assign b4_g32[0] = ~(~g08[4] & (~t08[4] | ~g08[5]));
   assign b4_g32[1] = ~(~g08[6] & (~t08[6] | g7c_b));
   assign b4_t32    = t08[4] & t08[5];
   assign c64_b[4]  = ~(b4_g32[0] | (b4_t32 & b4_g32[1]));

   // bytes 5..7
   assign b5_g32[0] = ~(~g08[5] & (~t08[5] | ~g08[6]));
   assign b5_g32[1] = ~g7c_b;
   assign b5_t32    = t08[5] & t08[6];
   assign c64_b[5]  = ~(b5_g32[0] | (b5_t32 & b5_g32[1]));

   // bytes 6 and 7
   assign b6_g32   = ~(~g08[6] & (~t08[6] | g7c_b));
   assign c64_b[6] = ~b6_g32;

   // byte 7 sees only its own group and ci
   assign c64_b[7] = g7c_b;

endmodule

//--- verilog/add_byte_gp.sv
//--------------------
// Adder byte groups
// Per-byte group generate and transmit, plus the two
// conditional byte sums for a carry-in of 0 and of 1.
//--------------------

`timescale 1ns/1ps

module add_byte_gp (
   input  add_pkg::add_word_t x,
   input  add_pkg::add_word_t y,
   output add_pkg::byte_sig_t g08,
   output add_pkg::byte_sig_t t08,
   output add_pkg::add_word_t sum0,
   output add_pkg::add_word_t sum1
);

   add_pkg::add_word_t gen;
   add_pkg::add_word_t prp;

   // bit generate and propagate
   assign gen = x & y;
   assign prp = x ^ y;

   always_comb begin
      logic c0;
      logic c1;
      logic tt;
      int   b;

      for (int k = 0; k < 8; k++) begin
         c0 = 1'b0;
         c1 = 1'b1;
         tt = 1'b1;
         // ripple from the byte lsb (bit 8k+7) up to its msb
         for (int i = 7; i >= 0; i--) begin
            b = 8 * k + i;
            sum0[b] = prp[b] ^ c0;
            sum1[b] = prp[b] ^ c1;
            c0 = gen[b] | (prp[b] & c0);
            c1 = gen[b] | (prp[b] & c1);
            tt = tt & prp[b];
         end
         // carry out with no carry in is the group generate
         g08[k] = c0;
         // carry passes only if every bit propagates
         t08[k] = tt;
      end
   end

endmodule

//--- verilog/add_pkg.sv
//--------------------
// Adder shared types
// Operand, byte signal and opcode types plus the request and
// response structs of the 64-bit adder unit. Bit 0 and byte 0
// are the most significant.
//--------------------

package add_pkg;

   // full operand or result word, bit 0 is the msb
   typedef logic [0:63] add_word_t;

   // one signal per byte, byte 0 is the most significant
   typedef logic [0:7] byte_sig_t;

   typedef enum logic [1:0] {
      op_add = 2'b00,
      op_sub = 2'b01,
      op_adc = 2'b10
   } add_op_e;

   // one operation, 131 bits
   typedef struct packed {
      add_word_t a;
      add_word_t b;
      add_op_e   op;
      logic      cin;
   } add_req_t;

   // one result with flags, 67 bits
   typedef struct packed {
      add_word_t sum;
      logic      cout;
      logic      ovf;
      logic      zero;
   } add_rsp_t;

endpackage
